// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
TOP       ?= tb_periph_domain
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJDIR)

// ==== hdl/addr_demux.sv ====
// --------------------
// Single-manager address decoder with request fan-out and response return
// Unmapped addresses are answered by a built-in error responder
// --------------------

`timescale 1ns/1ps

module addr_demux import domain_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      obi_req_i,
  input  logic      obi_we_i,
  input  bus_addr_t obi_addr_i,
  input  strb_t     obi_be_i,
  input  data_t     obi_wdata_i,
  output logic      obi_gnt_o,
  output logic      obi_rvalid_o,
  output logic      obi_err_o,
  output data_t     obi_rdata_o,

  obi_if.manager    sram_o,
  obi_if.manager    soc_o,
  obi_if.manager    gpio_o
);

  logic       sel_sram;
  logic       sel_soc;
  logic       sel_gpio;
  logic       sel_err;
  logic       accept;
  // One-hot of the target accepted last cycle: {err, gpio, soc, sram}
  logic [3:0] rsp_sel_q;

  // --------------------
  // Decode
  // --------------------
  assign sel_sram = (obi_addr_i.fields.region == RegionSram) &&
                    (obi_addr_i.fields.block == 12'h000);
  assign sel_soc  = (obi_addr_i.fields.region == RegionPeriph) &&
                    (obi_addr_i.fields.block == BlockSocCtrl);
  assign sel_gpio = (obi_addr_i.fields.region == RegionPeriph) &&
                    (obi_addr_i.fields.block == BlockGpio);
  assign sel_err  = ~(sel_sram | sel_soc | sel_gpio);

  // --------------------
  // Request fan-out
  // --------------------
  // Fields go to every target, only req is steered
  assign sram_o.req   = obi_req_i & sel_sram;
  assign sram_o.addr  = obi_addr_i;
  assign sram_o.we    = obi_we_i;
  assign sram_o.be    = obi_be_i;
  assign sram_o.wdata = obi_wdata_i;

  assign soc_o.req    = obi_req_i & sel_soc;
  assign soc_o.addr   = obi_addr_i;
  assign soc_o.we     = obi_we_i;
  assign soc_o.be     = obi_be_i;
  assign soc_o.wdata  = obi_wdata_i;

  assign gpio_o.req   = obi_req_i & sel_gpio;
  assign gpio_o.addr  = obi_addr_i;
  assign gpio_o.we    = obi_we_i;
  assign gpio_o.be    = obi_be_i;
  assign gpio_o.wdata = obi_wdata_i;

  // Error responder always grants
  assign obi_gnt_o = (sel_sram & sram_o.gnt) |
                     (sel_soc & soc_o.gnt) |
                     (sel_gpio & gpio_o.gnt) |
                     sel_err;

  assign accept = obi_req_i & obi_gnt_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_sel_q <= '0;
    end else if (accept) begin
      rsp_sel_q <= {sel_err, sel_gpio, sel_soc, sel_sram};
    end else begin
      rsp_sel_q <= '0;
    end
  end

  // --------------------
  // Response return
  // --------------------
  always_comb begin
    obi_rvalid_o = 1'b0;
    obi_rdata_o  = '0;
    obi_err_o    = 1'b0;
    if (rsp_sel_q[0]) begin
      obi_rvalid_o = sram_o.rvalid;
      obi_rdata_o  = sram_o.rdata;
      obi_err_o    = sram_o.err;
    end
    if (rsp_sel_q[1]) begin
      obi_rvalid_o = soc_o.rvalid;
      obi_rdata_o  = soc_o.rdata;
      obi_err_o    = soc_o.err;
    end
    if (rsp_sel_q[2]) begin
      obi_rvalid_o = gpio_o.rvalid;
      obi_rdata_o  = gpio_o.rdata;
      obi_err_o    = gpio_o.err;
    end
    // Unmapped access, reads and writes alike
    if (rsp_sel_q[3]) begin
      obi_rvalid_o = 1'b1;
      obi_rdata_o  = ErrRspData;
      obi_err_o    = 1'b1;
    end
  end

endmodule

// ==== hdl/domain_pkg.sv ====
// --------------------
// Address map, bus widths and register offsets shared by the peripheral domain
// Imported by every design module and by the bus interface
// --------------------

package domain_pkg;

  // --------------------
  // Bus and memory sizes
  // --------------------
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned StrbWidth    = DataWidth / 8;
  localparam int unsigned GpioCount    = 16;
  localparam int unsigned SramWords    = 1024;
  localparam int unsigned SramIdxWidth = $clog2(SramWords);

  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [GpioCount-1:0] gpio_t;

  // --------------------
  // Address map
  // --------------------
  // Top byte selects the region, bits 23..12 the block inside it
  localparam logic [7:0]  RegionSram   = 8'h10;
  localparam logic [7:0]  RegionPeriph = 8'h03;
  localparam logic [11:0] BlockSocCtrl = 12'h000;
  localparam logic [11:0] BlockGpio    = 12'h005;

  localparam data_t SramBaseAddr = 32'h1000_0000;
  localparam data_t ErrRspData   = 32'hBADC_AB1E;

  // SoC control offsets
  localparam logic [11:0] OffBootAddr = 12'h000;
  localparam logic [11:0] OffFetchEn  = 12'h004;

  // GPIO offsets
  localparam logic [11:0] OffDir       = 12'h000;
  localparam logic [11:0] OffOut       = 12'h004;
  localparam logic [11:0] OffIn        = 12'h008;
  localparam logic [11:0] OffIrqEn     = 12'h00C;
  localparam logic [11:0] OffIrqStatus = 12'h010;

  // Bus address, either as a plain word or split for decoding
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [7:0]  region;
      logic [11:0] block;
      logic [11:0] offset;
    } fields;
  } bus_addr_t;

  // Replace only the bytes whose enable is set
  function automatic data_t merge_be(data_t old_word, data_t new_word, strb_t be);
    data_t result;
    result = old_word;
    for (int b = 0; b < StrbWidth; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== hdl/gpio_regs.sv ====
// --------------------
// GPIO block with direction, output, synchronized input and edge interrupt
// --------------------

`timescale 1ns/1ps

module gpio_regs import domain_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  obi_if.subordinate bus_i,
  input  gpio_t      gpio_i,
  output gpio_t      gpio_o,
  output gpio_t      gpio_out_en_o,
  output gpio_t      gpio_in_sync_o,
  output logic       irq_o
);

  gpio_t dir_q;
  gpio_t out_q;
  gpio_t irq_en_q;
  gpio_t status_q;
  gpio_t sync1_q;
  gpio_t sync2_q;
  gpio_t prev_q;
  gpio_t rise;
  gpio_t status_clr;
  logic  accept;
  logic  wr_en;
  logic  rvalid_q;
  data_t rdata_q;
  data_t rdata_d;

  assign bus_i.gnt = bus_i.req;
  assign accept    = bus_i.req & bus_i.gnt;
  assign wr_en     = accept & bus_i.we;

  // --------------------
  // Input sync and edges
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;

  // Write-one-to-clear mask for the status register
  assign status_clr = (wr_en && bus_i.addr.fields.offset == OffIrqStatus) ?
                      gpio_t'(merge_be('0, bus_i.wdata, bus_i.be)) : '0;

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dir_q    <= '0;
      out_q    <= '0;
      irq_en_q <= '0;
      status_q <= '0;
    end else begin
      if (wr_en && bus_i.addr.fields.offset == OffDir) begin
        dir_q <= gpio_t'(merge_be(data_t'(dir_q), bus_i.wdata, bus_i.be));
      end
      if (wr_en && bus_i.addr.fields.offset == OffOut) begin
        out_q <= gpio_t'(merge_be(data_t'(out_q), bus_i.wdata, bus_i.be));
      end
      if (wr_en && bus_i.addr.fields.offset == OffIrqEn) begin
        irq_en_q <= gpio_t'(merge_be(data_t'(irq_en_q), bus_i.wdata, bus_i.be));
      end
      // New edge wins over a clear in the same cycle
      status_q <= (status_q & ~status_clr) | (rise & irq_en_q);
    end
  end

  always_comb begin
    case (bus_i.addr.fields.offset)
      OffDir:       rdata_d = data_t'(dir_q);
      OffOut:       rdata_d = data_t'(out_q);
      OffIn:        rdata_d = data_t'(sync2_q);
      OffIrqEn:     rdata_d = data_t'(irq_en_q);
      OffIrqStatus: rdata_d = data_t'(status_q);
      default:      rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= bus_i.we ? '0 : rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = sync2_q;
  assign irq_o          = |status_q;

endmodule

// ==== hdl/obi_if.sv ====
// --------------------
// OBI request/grant/response bus between the address decoder and one target
// --------------------

`timescale 1ns/1ps

interface obi_if import domain_pkg::*; ();

  // Request channel
  logic      req;
  bus_addr_t addr;
  logic      we;
  strb_t     be;
  data_t     wdata;

  // Grant and response channel
  logic      gnt;
  logic      rvalid;
  data_t     rdata;
  logic      err;

  modport manager (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport subordinate (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// ==== hdl/periph_domain.sv ====
// --------------------
// Memory and peripheral domain with one OBI port, SRAM, SoC control and GPIO
// --------------------

`timescale 1ns/1ps

module periph_domain import domain_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      fetch_en_i,

  // Manager-side bus
  input  logic      obi_req_i,
  input  logic      obi_we_i,
  input  bus_addr_t obi_addr_i,
  input  strb_t     obi_be_i,
  input  data_t     obi_wdata_i,
  output logic      obi_gnt_o,
  output logic      obi_rvalid_o,
  output logic      obi_err_o,
  output data_t     obi_rdata_o,

  // Pins
  input  gpio_t     gpio_i,
  output gpio_t     gpio_o,
  output gpio_t     gpio_out_en_o,
  output gpio_t     gpio_in_sync_o,
  output logic      gpio_irq_o,

  // Boot control
  output logic      fetch_enable_o,
  output data_t     boot_addr_o
);

  obi_if sram_bus ();
  obi_if soc_bus ();
  obi_if gpio_bus ();

  addr_demux i_addr_demux (
    .clk_i,
    .reset_i,
    .obi_req_i,
    .obi_we_i,
    .obi_addr_i,
    .obi_be_i,
    .obi_wdata_i,
    .obi_gnt_o,
    .obi_rvalid_o,
    .obi_err_o,
    .obi_rdata_o,
    .sram_o       ( sram_bus.manager ),
    .soc_o        ( soc_bus.manager  ),
    .gpio_o       ( gpio_bus.manager )
  );

  sram_bank i_sram_bank (
    .clk_i,
    .reset_i,
    .bus_i   ( sram_bus.subordinate )
  );

  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i,
    .reset_i,
    .bus_i          ( soc_bus.subordinate ),
    .fetch_en_i,
    .fetch_enable_o,
    .boot_addr_o
  );

  gpio_regs i_gpio_regs (
    .clk_i,
    .reset_i,
    .bus_i          ( gpio_bus.subordinate ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o,
    .irq_o          ( gpio_irq_o )
  );

endmodule

// ==== hdl/soc_ctrl_regs.sv ====
// --------------------
// SoC control registers holding the boot address and the fetch enable
// --------------------

`timescale 1ns/1ps

module soc_ctrl_regs import domain_pkg::*; (
  input  logic       clk_i,
  input  logic       reset_i,
  obi_if.subordinate bus_i,
  input  logic       fetch_en_i,
  output logic       fetch_enable_o,
  output data_t      boot_addr_o
);

  data_t boot_addr_q;
  logic  fetch_en_q;
  logic  accept;
  logic  wr_boot;
  logic  wr_fetch;
  logic  rvalid_q;
  data_t rdata_q;
  data_t rdata_d;

  assign bus_i.gnt = bus_i.req;
  assign accept    = bus_i.req & bus_i.gnt;
  assign wr_boot   = accept & bus_i.we & (bus_i.addr.fields.offset == OffBootAddr);
  assign wr_fetch  = accept & bus_i.we & (bus_i.addr.fields.offset == OffFetchEn);

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      boot_addr_q <= SramBaseAddr;
      fetch_en_q  <= 1'b0;
    end else begin
      if (wr_boot) begin
        boot_addr_q <= merge_be(boot_addr_q, bus_i.wdata, bus_i.be);
      end
      // Fetch enable lives in bit 0 only
      if (wr_fetch && bus_i.be[0]) begin
        fetch_en_q <= bus_i.wdata[0];
      end
    end
  end

  // Read mux
  always_comb begin
    case (bus_i.addr.fields.offset)
      OffBootAddr: rdata_d = boot_addr_q;
      OffFetchEn:  rdata_d = data_t'(fetch_en_q);
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= bus_i.we ? '0 : rdata_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

  // External pin can start the core on its own
  assign fetch_enable_o = fetch_en_q | fetch_en_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

// ==== hdl/sram_bank.sv ====
// --------------------
// Single-port word SRAM with byte enables and one-cycle response
// --------------------

`timescale 1ns/1ps

module sram_bank import domain_pkg::*; (
  input  logic           clk_i,
  input  logic           reset_i,
  obi_if.subordinate     bus_i
);

  data_t                   mem_q [SramWords];
  logic [SramIdxWidth-1:0] word_idx;
  logic                    accept;
  logic                    rvalid_q;
  data_t                   rdata_q;

  // Word index from the byte offset
  assign word_idx = bus_i.addr.fields.offset[SramIdxWidth+1:2];
  assign bus_i.gnt = bus_i.req;
  assign accept    = bus_i.req & bus_i.gnt;

  // Byte-enabled write
  always_ff @(posedge clk_i) begin
    if (accept && bus_i.we) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (bus_i.be[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read data, zero for writes
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= bus_i.we ? '0 : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= accept;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

endmodule

// ==== verification/tb_model.svh ====
// --------------------
// Reference model of the SRAM and registers, and the compare tasks
// Included inside the testbench module body
// --------------------

`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Model state
data_t                   model_mem [SramWords];
logic [SramIdxWidth-1:0] model_idx_q [$];
data_t                   model_boot;
logic                    model_fetch;
gpio_t                   model_dir;
gpio_t                   model_out;
gpio_t                   model_irq_en;

int unsigned mismatch_count;
int unsigned timeout_count;

// Expand the enables into a bit mask and blend the two words
function automatic data_t blend_bytes(data_t old_word, data_t new_word, strb_t be);
  data_t mask;
  mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  return (old_word & ~mask) | (new_word & mask);
endfunction

function automatic void reset_model();
  model_boot   = 32'h1000_0000;
  model_fetch  = 1'b0;
  model_dir    = '0;
  model_out    = '0;
  model_irq_en = '0;
  model_idx_q.delete();
endfunction

// --------------------
// Compare tasks
// --------------------
task automatic check_data(input string name, input data_t got, input data_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    mismatch_count++;
  end
endtask

task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    mismatch_count++;
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("[FAIL] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    mismatch_count++;
  end
endtask

`endif

// ==== verification/tb_periph_domain.sv ====
// --------------------
// Random testbench for the peripheral domain, checked against a local model
// --------------------

`timescale 1ns/1ps

module tb_periph_domain import domain_pkg::*; ();

  localparam int unsigned WaitLimit = 20;
  localparam int unsigned B2bCount  = 32;

  logic      clk_i;
  logic      reset_i;
  logic      fetch_en_i;
  logic      obi_req_i;
  logic      obi_we_i;
  bus_addr_t obi_addr_i;
  strb_t     obi_be_i;
  data_t     obi_wdata_i;
  logic      obi_gnt_o;
  logic      obi_rvalid_o;
  logic      obi_err_o;
  data_t     obi_rdata_o;
  gpio_t     gpio_i;
  gpio_t     gpio_o;
  gpio_t     gpio_out_en_o;
  gpio_t     gpio_in_sync_o;
  logic      gpio_irq_o;
  logic      fetch_enable_o;
  data_t     boot_addr_o;
  logic [15:0] lfsr_q;

  `include "tb_model.svh"

  periph_domain i_dut (
    .clk_i, .reset_i, .fetch_en_i,
    .obi_req_i, .obi_we_i, .obi_addr_i, .obi_be_i, .obi_wdata_i,
    .obi_gnt_o, .obi_rvalid_o, .obi_err_o, .obi_rdata_o,
    .gpio_i, .gpio_o, .gpio_out_en_o, .gpio_in_sync_o, .gpio_irq_o,
    .fetch_enable_o, .boot_addr_o
  );

  always #10 clk_i = ~clk_i;

  // --------------------
  // Random source
  // --------------------
  // Taps 16, 14, 13, 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic data_t rand_bits(int unsigned n);
    data_t v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[DataWidth-2:0], lfsr_bit()};
    end
    return v;
  endfunction

  // --------------------
  // Addresses
  // --------------------
  function automatic bus_addr_t make_addr(logic [7:0] region, logic [11:0] block,
                                          logic [11:0] offset);
    bus_addr_t a;
    a.fields.region = region;
    a.fields.block  = block;
    a.fields.offset = offset;
    return a;
  endfunction

  function automatic bus_addr_t sram_addr(logic [SramIdxWidth-1:0] idx);
    return make_addr(8'h10, 12'h000, {idx, 2'b00});
  endfunction

  function automatic bus_addr_t soc_addr(logic [11:0] offset);
    return make_addr(8'h03, 12'h000, offset);
  endfunction

  function automatic bus_addr_t gpio_addr(logic [11:0] offset);
    return make_addr(8'h03, 12'h005, offset);
  endfunction

  // Random word with the top byte moved out of both mapped regions
  function automatic bus_addr_t unmapped_addr();
    bus_addr_t a;
    a.raw = rand_bits(AddrWidth);
    if (a.fields.region == 8'h10 || a.fields.region == 8'h03) begin
      a.fields.region = a.fields.region ^ 8'h80;
    end
    return a;
  endfunction

  function automatic logic [SramIdxWidth-1:0] pick_written();
    int unsigned pick;
    pick = rand_bits(5) % model_idx_q.size();
    return model_idx_q[pick];
  endfunction

  // --------------------
  // Bus driver
  // --------------------
  task automatic bus_transfer(input logic we, input bus_addr_t addr, input strb_t be,
                              input data_t wdata, output data_t rdata, output logic err);
    int unsigned waited;
    @(posedge clk_i);
    obi_req_i   <= 1'b1;
    obi_we_i    <= we;
    obi_addr_i  <= addr;
    obi_be_i    <= be;
    obi_wdata_i <= wdata;
    waited = 0;
    @(negedge clk_i);
    while (obi_gnt_o !== 1'b1 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (obi_gnt_o !== 1'b1) begin
      $display("Timed out waiting for a grant at address 0x%h", addr);
      timeout_count++;
    end
    @(posedge clk_i);
    obi_req_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (obi_rvalid_o !== 1'b1 && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (obi_rvalid_o !== 1'b1) begin
      $display("Timed out waiting for a response at address 0x%h", addr);
      timeout_count++;
    end
    rdata = obi_rdata_o;
    err   = obi_err_o;
  endtask

  task automatic access_check(input logic we, input bus_addr_t addr, input strb_t be,
                              input data_t wdata, input data_t exp_rdata, input logic exp_err);
    data_t rdata;
    logic  err;
    bus_transfer(we, addr, be, wdata, rdata, err);
    check_data("obi_rdata_o", rdata, exp_rdata);
    check_bit("obi_err_o", err, exp_err);
  endtask

  // --------------------
  // Behaviors
  // --------------------
  task automatic sram_rw();
    logic [SramIdxWidth-1:0] idx;
    data_t wdata;
    strb_t be;
    // Full words first so that every read hits a defined word
    for (int k = 0; k < 12; k++) begin
      idx   = SramIdxWidth'(rand_bits(SramIdxWidth));
      wdata = rand_bits(DataWidth);
      model_mem[idx] = wdata;
      model_idx_q.push_back(idx);
      access_check(1'b1, sram_addr(idx), 4'hF, wdata, '0, 1'b0);
    end
    for (int k = 0; k < 24; k++) begin
      idx   = pick_written();
      wdata = rand_bits(DataWidth);
      be    = strb_t'(rand_bits(StrbWidth));
      model_mem[idx] = blend_bytes(model_mem[idx], wdata, be);
      access_check(1'b1, sram_addr(idx), be, wdata, '0, 1'b0);
    end
    foreach (model_idx_q[k]) begin
      idx = model_idx_q[k];
      access_check(1'b0, sram_addr(idx), 4'hF, '0, model_mem[idx], 1'b0);
    end
  endtask

  task automatic unmapped_rw();
    logic      we;
    bus_addr_t addr;
    for (int k = 0; k < 8; k++) begin
      we   = rand_bits(1) != 0;
      addr = unmapped_addr();
      // Same offset as a written SRAM word, so a leaked write would corrupt it
      addr.fields.offset = {model_idx_q[0], 2'b00};
      access_check(we, addr, 4'hF, rand_bits(DataWidth), 32'hBADC_AB1E, 1'b1);
    end
    access_check(1'b0, sram_addr(model_idx_q[0]), 4'hF, '0, model_mem[model_idx_q[0]], 1'b0);
  endtask

  task automatic boot_ctrl();
    data_t wdata;
    strb_t be;
    check_data("boot_addr_o", boot_addr_o, 32'h1000_0000);
    for (int k = 0; k < 6; k++) begin
      @(posedge clk_i);
      fetch_en_i <= rand_bits(1) != 0;
      @(negedge clk_i);
      check_bit("fetch_enable_o", fetch_enable_o, model_fetch | fetch_en_i);
      wdata = rand_bits(DataWidth);
      be    = strb_t'(rand_bits(StrbWidth));
      model_boot = blend_bytes(model_boot, wdata, be);
      access_check(1'b1, soc_addr(12'h000), be, wdata, '0, 1'b0);
      check_data("boot_addr_o", boot_addr_o, model_boot);
      access_check(1'b0, soc_addr(12'h000), 4'hF, '0, model_boot, 1'b0);
      wdata = rand_bits(DataWidth);
      model_fetch = wdata[0];
      access_check(1'b1, soc_addr(12'h004), 4'hF, wdata, '0, 1'b0);
      check_bit("fetch_enable_o", fetch_enable_o, model_fetch | fetch_en_i);
      access_check(1'b0, soc_addr(12'h004), 4'hF, '0, data_t'(model_fetch), 1'b0);
    end
  endtask

  task automatic gpio_pins();
    gpio_t pins;
    for (int k = 0; k < 4; k++) begin
      model_dir = gpio_t'(rand_bits(GpioCount));
      access_check(1'b1, gpio_addr(12'h000), 4'hF, data_t'(model_dir), '0, 1'b0);
      check_gpio("gpio_out_en_o", gpio_out_en_o, model_dir);
      model_out = gpio_t'(rand_bits(GpioCount));
      access_check(1'b1, gpio_addr(12'h004), 4'hF, data_t'(model_out), '0, 1'b0);
      check_gpio("gpio_o", gpio_o, model_out);
      access_check(1'b0, gpio_addr(12'h000), 4'hF, '0, data_t'(model_dir), 1'b0);
      pins = gpio_t'(rand_bits(GpioCount));
      @(posedge clk_i);
      gpio_i <= pins;
      // Two sync flops plus margin
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      check_gpio("gpio_in_sync_o", gpio_in_sync_o, pins);
      access_check(1'b0, gpio_addr(12'h008), 4'hF, '0, data_t'(pins), 1'b0);
    end
  endtask

  task automatic gpio_irq();
    gpio_t pins;
    gpio_t expected;
    for (int k = 0; k < 4; k++) begin
      @(posedge clk_i);
      gpio_i <= '0;
      repeat (4) @(posedge clk_i);
      model_irq_en = gpio_t'(rand_bits(GpioCount));
      access_check(1'b1, gpio_addr(12'h00C), 4'hF, data_t'(model_irq_en), '0, 1'b0);
      access_check(1'b1, gpio_addr(12'h010), 4'hF, 32'hFFFF_FFFF, '0, 1'b0);
      check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
      pins = gpio_t'(rand_bits(GpioCount));
      @(posedge clk_i);
      gpio_i <= pins;
      // Status is set one cycle after the synchronized edge
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      expected = pins & model_irq_en;
      check_bit("gpio_irq_o", gpio_irq_o, |expected);
      access_check(1'b0, gpio_addr(12'h010), 4'hF, '0, data_t'(expected), 1'b0);
      access_check(1'b1, gpio_addr(12'h010), 4'hF, data_t'(expected), '0, 1'b0);
      check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
      access_check(1'b0, gpio_addr(12'h010), 4'hF, '0, '0, 1'b0);
    end
  endtask

  task automatic back_to_back();
    data_t     exp_data_q [$];
    logic      exp_err_q [$];
    logic [SramIdxWidth-1:0] idx;
    bus_addr_t addr;
    data_t     wdata;
    data_t     exp;
    strb_t     be;
    logic      we;
    logic      err;
    int unsigned op;
    for (int k = 0; k <= B2bCount; k++) begin
      @(posedge clk_i);
      if (k < B2bCount) begin
        we    = rand_bits(1) != 0;
        wdata = rand_bits(DataWidth);
        be    = 4'hF;
        exp   = '0;
        err   = 1'b0;
        op    = rand_bits(2);
        case (op)
          0: begin
            idx  = pick_written();
            addr = sram_addr(idx);
            be   = strb_t'(rand_bits(StrbWidth));
            if (we) model_mem[idx] = blend_bytes(model_mem[idx], wdata, be);
            else exp = model_mem[idx];
          end
          1: begin
            addr = soc_addr(12'h000);
            if (we) model_boot = wdata;
            else exp = model_boot;
          end
          2: begin
            addr = gpio_addr(12'h004);
            if (we) model_out = gpio_t'(wdata);
            else exp = data_t'(model_out);
          end
          default: begin
            addr = unmapped_addr();
            exp  = 32'hBADC_AB1E;
            err  = 1'b1;
          end
        endcase
        exp_data_q.push_back(exp);
        exp_err_q.push_back(err);
        obi_req_i   <= 1'b1;
        obi_we_i    <= we;
        obi_addr_i  <= addr;
        obi_be_i    <= be;
        obi_wdata_i <= wdata;
      end else begin
        obi_req_i <= 1'b0;
      end
      @(negedge clk_i);
      if (k < B2bCount) begin
        check_bit("obi_gnt_o", obi_gnt_o, 1'b1);
      end
      // Response of the previous cycle's request
      if (k > 0) begin
        check_bit("obi_rvalid_o", obi_rvalid_o, 1'b1);
        check_data("obi_rdata_o", obi_rdata_o, exp_data_q.pop_front());
        check_bit("obi_err_o", obi_err_o, exp_err_q.pop_front());
      end
    end
    check_data("boot_addr_o", boot_addr_o, model_boot);
    check_gpio("gpio_o", gpio_o, model_out);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fetch_en_i     = 1'b0;
    obi_req_i      = 1'b0;
    obi_we_i       = 1'b0;
    obi_addr_i     = '0;
    obi_be_i       = '0;
    obi_wdata_i    = '0;
    gpio_i         = '0;
    lfsr_q         = 16'd24;
    mismatch_count = 0;
    timeout_count  = 0;
    reset_model();
    repeat (16) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_bit("obi_rvalid_o", obi_rvalid_o, 1'b0);
    check_gpio("gpio_o", gpio_o, '0);
    check_gpio("gpio_out_en_o", gpio_out_en_o, '0);
    check_bit("gpio_irq_o", gpio_irq_o, 1'b0);
    check_bit("fetch_enable_o", fetch_enable_o, fetch_en_i);
    sram_rw();
    unmapped_rw();
    boot_ctrl();
    gpio_pins();
    gpio_irq();
    back_to_back();
    $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+verification
hdl/domain_pkg.sv
hdl/obi_if.sv
hdl/addr_demux.sv
hdl/sram_bank.sv
hdl/soc_ctrl_regs.sv
hdl/gpio_regs.sv
hdl/periph_domain.sv
verification/tb_periph_domain.sv
